// File: Makefile
TOP = cpuAluCoreTb

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: all.f
source/cpuPkg.sv
source/phaseSequencer.sv
source/aluGroupDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/cpuAluCore.sv
tb/cpuAluCore_assert.sv
tb/cpuAluCoreTb.sv

// File: source/aluGroupDecoder.sv
// group 3 decoder: operand/address selects and phased register-file and flag-load enables
`timescale 1ns/1ps

module aluGroupDecoder (
	input  logic             CLK,
	input  logic             rstN,
	input  cpuPkg::instrWord instrReg,
	input  logic             fetch,
	input  logic             decode,
	input  logic             execute,
	input  logic             commit,
	output logic             regAEn,
	output logic             regBEn,
	output logic             regAWen,
	output logic [3:0]       regAddrA,
	output logic [3:0]       regAddrB,
	output cpuPkg::srcASel   srcA,
	output cpuPkg::srcBSel   srcB,
	output cpuPkg::aluOp     op,
	output logic             ccLd,
	output logic [7:0]       imm
);

	import cpuPkg::*;

	logic isAlu;  // group 3 word
	logic flagOp; // operation that updates C/Z/N
	logic rdA;
	logic rdB;
	logic wrA;

	assign isAlu = (instrReg.aluView.group == GROUP_ALU);
	assign op    = instrReg.aluView.op;
	assign imm   = instrReg.immView.imm8; // U4 rides in the low nibble

	// MOV and the reserved codes leave flags alone
	assign flagOp = (op != OP_MOV) && (op <= OP_SHR);

	// argument type decode
	always_comb begin
		srcA     = SRCA_REG;
		srcB     = SRCB_REG;
		regAddrA = instrReg.aluView.argA;
		regAddrB = instrReg.aluView.argB;
		rdA      = 1'b0;
		rdB      = 1'b0;
		wrA      = 1'b0;
		case (instrReg.aluView.mode)
			MODE_REG_REG: begin // Ra op Rb
				rdA = 1'b1;
				rdB = 1'b1;
				wrA = 1'b1;
			end
			MODE_REG_U4: begin // Ra op u4
				srcB = SRCB_U4;
				rdA  = 1'b1;
				wrA  = 1'b1;
			end
			MODE_RB_U8: begin
				regAddrA = REG_RB; // port A only addresses the target
				srcA     = SRCA_ZERO;
				srcB     = SRCB_U8;
				rdA      = 1'b1;
				wrA      = 1'b1;
			end
			MODE_RA_U8RB: begin
				regAddrA = REG_RA;
				regAddrB = REG_RB; // low byte source
				srcA     = SRCA_ZERO;
				srcB     = SRCB_U8H;
				rdA      = 1'b1;
				rdB      = 1'b1;
				wrA      = 1'b1;
			end
			default: ;
		endcase
		// other groups pass through without touching registers
		if (!isAlu) begin
			rdA = 1'b0;
			rdB = 1'b0;
			wrA = 1'b0;
		end
	end

	// each enable is loaded one phase ahead of the cycle it serves
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			regAEn  <= 1'b0;
			regBEn  <= 1'b0;
			regAWen <= 1'b0;
			ccLd    <= 1'b0;
		end else if (fetch) begin
			regAEn  <= 1'b0;
			regBEn  <= 1'b0;
			regAWen <= 1'b0;
			ccLd    <= 1'b0;
		end else if (decode) begin
			regAEn <= rdA; // reads live through execute and commit
			regBEn <= rdB;
			ccLd   <= isAlu && flagOp; // high for the execute cycle only
		end else if (execute) begin
			ccLd    <= 1'b0;
			regAWen <= wrA; // write-back during commit
		end else if (commit) begin
			regAEn  <= 1'b0;
			regBEn  <= 1'b0;
			regAWen <= 1'b0;
		end
	end

endmodule

// File: source/aluUnit.sv
// ALU: operand muxes, eight operations, result register and C/Z/N condition register
`timescale 1ns/1ps

module aluUnit (
	input  logic           CLK,
	input  logic           rstN,
	input  logic [15:0]    rdDataA,
	input  logic [15:0]    rdDataB,
	input  cpuPkg::srcASel srcA,
	input  cpuPkg::srcBSel srcB,
	input  cpuPkg::aluOp   op,
	input  logic [7:0]     imm,
	input  logic           ccLd,
	output logic [15:0]    result,
	output logic [2:0]     flags
);

	import cpuPkg::*;

	logic [15:0] opA;
	logic [15:0] opB;
	logic [15:0] aluOut;
	logic        carry;
	logic [2:0]  flagsNext;

	assign opA = (srcA == SRCA_ZERO) ? 16'h0000 : rdDataA;

	always_comb begin
		case (srcB)
			SRCB_U4:  opB = {12'h000, imm[3:0]};
			SRCB_U8:  opB = {8'h00, imm};
			SRCB_U8H: opB = {imm, rdDataB[7:0]}; // imm8 high, RB low byte
			default:  opB = rdDataB;
		endcase
	end

	always_comb begin
		carry = 1'b0; // logic ops and moves clear C
		case (op)
			OP_ADD:  {carry, aluOut} = {1'b0, opA} + {1'b0, opB};
			OP_SUB:  {carry, aluOut} = {1'b0, opA} - {1'b0, opB}; // bit 16 is borrow
			OP_AND:  aluOut = opA & opB;
			OP_OR:   aluOut = opA | opB;
			OP_XOR:  aluOut = opA ^ opB;
			OP_SHL: begin
				aluOut = {opA[14:0], 1'b0};
				carry  = opA[15]; // bit shifted out
			end
			OP_SHR: begin
				aluOut = {1'b0, opA[15:1]};
				carry  = opA[0];
			end
			default: aluOut = opB; // MOV and reserved codes
		endcase
	end

	always_comb begin
		flagsNext         = 3'b000;
		flagsNext[FLAG_C] = carry;
		flagsNext[FLAG_Z] = (aluOut == 16'h0000);
		flagsNext[FLAG_N] = aluOut[15];
	end

	// captured every clock, meaningful at the end of execute
	always_ff @(posedge CLK) begin
		result <= aluOut;
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			flags <= 3'b000;
		end else if (ccLd) begin
			flags <= flagsNext; // same edge as the result
		end
	end

endmodule

// File: source/cpuAluCore.sv
// ALU path top level: phase sequencer, group 3 decoder, register file and ALU
`timescale 1ns/1ps

module cpuAluCore (
	input  logic        CLK,
	input  logic        rstN,
	input  logic        instrStrobe,
	input  logic [15:0] instr,
	output logic        busy,
	output logic        resultValid,
	output logic [3:0]  resultAddr,
	output logic [15:0] resultData,
	output logic [2:0]  flags
);

	import cpuPkg::*;

	instrWord    instrReg;
	logic        fetch;
	logic        decode;
	logic        execute;
	logic        commit;
	logic        regAEn;
	logic        regBEn;
	logic        regAWen;
	logic [3:0]  regAddrA;
	logic [3:0]  regAddrB;
	srcASel      srcA;
	srcBSel      srcB;
	aluOp        op;
	logic        ccLd;
	logic [7:0]  imm;
	logic [15:0] rdDataA;
	logic [15:0] rdDataB;
	logic [15:0] result;

	// write-back trace mirrors the register-file write port
	assign resultValid = regAWen;
	assign resultAddr  = regAddrA;
	assign resultData  = result;

	phaseSequencer u_seq (
		.CLK         (CLK),
		.rstN        (rstN),
		.instrStrobe (instrStrobe),
		.instr       (instr),
		.instrReg    (instrReg),
		.fetch       (fetch),
		.decode      (decode),
		.execute     (execute),
		.commit      (commit),
		.busy        (busy)
	);

	aluGroupDecoder u_dec (
		.CLK(CLK), .rstN(rstN), .instrReg(instrReg),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.regAEn(regAEn), .regBEn(regBEn), .regAWen(regAWen),
		.regAddrA(regAddrA), .regAddrB(regAddrB),
		.srcA(srcA), .srcB(srcB), .op(op), .ccLd(ccLd), .imm(imm)
	);

	// operands in, ALU result back on the write port
	registerFile u_regs (
		.CLK(CLK), .rstN(rstN),
		.regAEn(regAEn), .regBEn(regBEn), .regAWen(regAWen),
		.regAddrA(regAddrA), .regAddrB(regAddrB),
		.wrData(result),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	aluUnit u_alu (
		.CLK(CLK), .rstN(rstN),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.srcA(srcA), .srcB(srcB), .op(op), .imm(imm),
		.ccLd(ccLd),
		.result(result),
		.flags(flags)
	);

endmodule

// File: source/cpuPkg.sv
// instruction word union, group/mode/operation enums, source selects, fixed registers, flag bits
package cpuPkg;

	// instruction group field, bits 15:14
	typedef enum logic [1:0] {
		GROUP_SYSTEM    = 2'd0,
		GROUP_LOADSTORE = 2'd1,
		GROUP_JUMP      = 2'd2,
		GROUP_ALU       = 2'd3
	} groupCode;

	// argument type field of an ALU word, bits 9:8
	typedef enum logic [1:0] {
		MODE_REG_REG  = 2'd0, // Ra op Rb -> Ra
		MODE_REG_U4   = 2'd1, // Ra op u4 -> Ra
		MODE_RB_U8    = 2'd2, // 0 op imm8 -> RB
		MODE_RA_U8RB  = 2'd3  // 0 op {imm8, RB[7:0]} -> RA
	} argMode;

	// ALU operation field, bits 13:10
	// codes 8..15 are reserved and act as a move
	typedef enum logic [3:0] {
		OP_MOV = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR  = 4'd4,
		OP_XOR = 4'd5,
		OP_SHL = 4'd6,
		OP_SHR = 4'd7
	} aluOp;

	typedef enum logic [1:0] {
		SRCA_REG  = 2'd0, // register port A
		SRCA_ZERO = 2'd1  // constant zero for the immediate modes
	} srcASel;

	typedef enum logic [1:0] {
		SRCB_REG  = 2'd0, // register port B
		SRCB_U4   = 2'd1, // argument B, zero extended
		SRCB_U8   = 2'd2, // imm8, zero extended
		SRCB_U8H  = 2'd3  // imm8 over low byte of port B
	} srcBSel;

	// register/register view
	typedef struct packed {
		groupCode   group;
		aluOp       op;
		argMode     mode;
		logic [3:0] argA;
		logic [3:0] argB;
	} aluFields;

	// immediate view, shares the upper byte with aluFields
	typedef struct packed {
		groupCode   group;
		aluOp       op;
		argMode     mode;
		logic [7:0] imm8;
	} immFields;

	typedef union packed {
		aluFields aluView;
		immFields immView;
	} instrWord;

	localparam logic [3:0] REG_RA = 4'd0; // target of the U8.RB mode
	localparam logic [3:0] REG_RB = 4'd1; // target of the U8 mode

	// bit positions in the 3-bit flag word
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;

endpackage

// File: source/phaseSequencer.sv
// instruction register, one-hot fetch/decode/execute/commit sequencer and busy flag
`timescale 1ns/1ps

module phaseSequencer (
	input  logic             CLK,
	input  logic             rstN,
	input  logic             instrStrobe,
	input  logic [15:0]      instr,
	output cpuPkg::instrWord instrReg,
	output logic             fetch,
	output logic             decode,
	output logic             execute,
	output logic             commit,
	output logic             busy
);

	logic [3:0] phase; // one-hot, bit 0 fetch .. bit 3 commit
	logic       accept;

	// no handshake, source waits for busy to drop
	assign busy   = |phase;
	assign accept = instrStrobe && !busy; // strobe while busy is dropped

	assign fetch   = phase[0];
	assign decode  = phase[1];
	assign execute = phase[2];
	assign commit  = phase[3];

	// phase walks one step per clock
	// commit shifts out to idle
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			phase <= 4'b0000;
		end else if (accept) begin
			phase <= 4'b0001; // fetch cycle follows the accepting edge
		end else begin
			phase <= phase << 1;
		end
	end

	// word held for the full four phases
	always_ff @(posedge CLK) begin
		if (accept) begin
			instrReg <= instr;
		end
	end

endmodule

// File: source/registerFile.sv
// sixteen 16-bit registers, two gated asynchronous read ports, one write port via port A
`timescale 1ns/1ps

module registerFile (
	input  logic        CLK,
	input  logic        rstN,
	input  logic        regAEn,
	input  logic        regBEn,
	input  logic        regAWen,
	input  logic [3:0]  regAddrA,
	input  logic [3:0]  regAddrB,
	input  logic [15:0] wrData,
	output logic [15:0] rdDataA,
	output logic [15:0] rdDataB
);

	logic [15:0] regs [16];
	logic        wrEn;

	// write only through an enabled port A
	assign wrEn = regAEn && regAWen;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'h0000; // whole file starts at zero
			end
		end else if (wrEn) begin
			regs[regAddrA] <= wrData;
		end
	end

	// disabled port reads as zero
	always_comb begin
		rdDataA = 16'h0000;
		rdDataB = 16'h0000;
		if (regAEn) begin
			rdDataA = regs[regAddrA];
		end
		if (regBEn) begin
			rdDataB = regs[regAddrB];
		end
	end

endmodule

// File: tb/cpuAluCoreTb.sv
// testbench with clock, reset, watchdog, reference model, xorshift generator and directed test tasks
`timescale 1ns/1ps

module cpuAluCoreTb;

	import cpuPkg::*;

	localparam int numInstr = 16 + 4 + 130 + 10 + 2 + 200; // words issued over all tests

	logic        CLK;
	logic        rstN;
	logic        instrStrobe;
	logic [15:0] instr;
	logic        busy;
	logic        resultValid;
	logic [3:0]  resultAddr;
	logic [15:0] resultData;
	logic [2:0]  flags;
	logic [15:0] mdlRegs [16]; // reference register file
	logic [2:0]  mdlFlags;
	logic [31:0] rngState;
	logic [3:0]  lastAddr;     // last write-back seen on the trace
	logic [15:0] lastData;
	int          errCount;

	cpuAluCore u_cpuAluCore (.CLK(CLK), .rstN(rstN), .instrStrobe(instrStrobe), .instr(instr),
		.busy(busy), .resultValid(resultValid), .resultAddr(resultAddr),
		.resultData(resultData), .flags(flags));

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK; // 100 ns period
	end

	initial begin
		#(numInstr * 6000 + 2000); // 6 us per word plus reset
		stopRun("watchdog timeout, the tests did not finish in time");
	end

	task automatic stopRun(input string line);
		errCount++;
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic valueError(input string msg);
		stopRun($sformatf("FAILED at %0t ns: %s", $time, msg));
	endtask

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13; // xorshift32
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic logic [15:0] aluWord(input logic [3:0] op, input logic [1:0] mode,
			input logic [3:0] a, input logic [3:0] b);
		return {2'b11, op, mode, a, b}; // imm8 is {a, b}
	endfunction

	// runs one word through the model and returns the expected write-back
	task automatic applyModel(input logic [15:0] w, output bit wr, output logic [3:0] dst,
			output logic [15:0] r);
		logic [15:0] x;
		logic [15:0] y;
		logic [16:0] wide;
		logic        c;
		wr  = (w[15:14] == GROUP_ALU);
		dst = w[7:4];
		x   = mdlRegs[w[7:4]];
		y   = mdlRegs[w[3:0]];
		r   = 16'h0000;
		c   = 1'b0;
		case (w[9:8])
			MODE_REG_U4: y = {12'h000, w[3:0]};
			MODE_RB_U8: begin
				dst = REG_RB;
				x   = 16'h0000;
				y   = {8'h00, w[7:0]};
			end
			MODE_RA_U8RB: begin
				dst = REG_RA;
				x   = 16'h0000;
				y   = {w[7:0], mdlRegs[REG_RB][7:0]}; // imm8 over RB low byte
			end
			default: ; // both registers read
		endcase
		case (w[13:10])
			OP_ADD: begin
				wide = {1'b0, x} + {1'b0, y};
				r    = wide[15:0];
				c    = wide[16]; // carry out
			end
			OP_SUB: begin
				r = x - y;
				c = (x < y); // borrow
			end
			OP_AND: r = x & y;
			OP_OR:  r = x | y;
			OP_XOR: r = x ^ y;
			OP_SHL: begin
				r = x << 1;
				c = x[15];
			end
			OP_SHR: begin
				r = x >> 1;
				c = x[0];
			end
			default: r = y; // MOV and reserved codes
		endcase
		if (wr) begin
			mdlRegs[dst] = r;
			if (w[13:10] != OP_MOV && w[13:10] < 4'd8) begin
				mdlFlags[FLAG_C] = c;
				mdlFlags[FLAG_Z] = (r == 16'h0000);
				mdlFlags[FLAG_N] = r[15];
			end
		end
	endtask

	// strobes one word and follows it until busy drops
	task automatic issueInstr(input logic [15:0] w, input bit extra, input logic [15:0] other);
		bit          expWr;
		logic [3:0]  expAddr;
		logic [15:0] expData;
		int          k;
		int          nValid;
		int          validAt;
		applyModel(w, expWr, expAddr, expData);
		k           = 0;
		nValid      = 0;
		validAt     = 0;
		instr       = w; // taken at the next rising edge
		instrStrobe = 1'b1;
		do begin
			@(negedge CLK);
			k++;
			if (k == 1) begin
				assert (busy) else valueError($sformatf("word %h not accepted", w));
				instr       = other; // second word lands while busy
				instrStrobe = extra;
			end else begin
				instrStrobe = 1'b0;
			end
			if (resultValid) begin
				nValid++;
				validAt  = k;
				lastAddr = resultAddr;
				lastData = resultData;
			end
		end while (busy && k < 8);
		assert (!busy) else stopRun($sformatf("busy stuck high after word %h", w));
		assert (k == 5) else valueError($sformatf("word %h busy for %0d cycles", w, k - 1));
		if (expWr) begin
			assert (nValid == 1 && validAt == 4) else valueError($sformatf(
				"word %h gave %0d write-backs, last in cycle %0d", w, nValid, validAt));
			assert (lastAddr == expAddr && lastData == expData) else valueError($sformatf(
				"word %h wrote R%0d=%h, expected R%0d=%h", w, lastAddr, lastData, expAddr, expData));
		end else begin
			assert (nValid == 0) else valueError($sformatf("word %h gave a write-back", w));
		end
		assert (flags == mdlFlags)
			else valueError($sformatf("word %h flags %b, expected %b", w, flags, mdlFlags));
	endtask

	task automatic issuePlain(input logic [15:0] w);
		issueInstr(w, 1'b0, 16'h0000);
	endtask

	// value built in RA through both immediate modes and moved
	task automatic loadReg(input logic [3:0] r, input logic [15:0] v);
		issuePlain(aluWord(OP_MOV, MODE_RB_U8, v[7:4], v[3:0]));
		issuePlain(aluWord(OP_MOV, MODE_RA_U8RB, v[15:12], v[11:8]));
		issuePlain(aluWord(OP_MOV, MODE_REG_REG, r, REG_RA));
	endtask

	task automatic resetStateTest();
		assert (!busy && !resultValid && flags == 3'b000)
			else valueError("outputs not idle after reset");
		for (int i = 0; i < 16; i++) begin
			issuePlain(aluWord(OP_MOV, MODE_REG_REG, 4'(i), 4'(i)));
			assert (lastData == 16'h0000) else valueError($sformatf("R%0d not cleared", i));
		end
	endtask

	task automatic immediateModesTest();
		issuePlain(aluWord(OP_ADD, MODE_RB_U8, 4'h5, 4'hA));
		assert (lastAddr == REG_RB && lastData == 16'h005A) else valueError("U8 add into RB");
		issuePlain(aluWord(OP_ADD, MODE_RA_U8RB, 4'hC, 4'h3));
		assert (lastAddr == REG_RA && lastData == 16'hC35A) else valueError("U8H add into RA");
		issuePlain(aluWord(OP_ADD, MODE_REG_U4, REG_RA, 4'h7));
		assert (lastData == 16'hC361) else valueError("U4 add to RA");
		issuePlain(aluWord(OP_SUB, MODE_REG_U4, REG_RA, 4'h1));
		assert (lastData == 16'hC360) else valueError("U4 sub from RA");
	endtask

	task automatic operationsTest();
		logic [3:0]  code;
		logic [31:0] rnd;
		for (int i = 0; i < 9; i++) begin
			code = (i == 8) ? 4'hB : 4'(i); // last pass uses a reserved code
			for (int t = 0; t < 2; t++) begin
				rnd = nextRand();
				loadReg(4'd2, rnd[15:0]);
				loadReg(4'd3, rnd[31:16]);
				if (code == OP_MOV || code > OP_SHR) begin
					// 0 - 1 into RB sets C and N for the move to keep
					issuePlain(aluWord(OP_SUB, MODE_RB_U8, 4'h0, 4'h1));
				end
				issuePlain(aluWord(code, MODE_REG_REG, 4'd2, 4'd3));
				if (code == OP_MOV || code > OP_SHR) begin
					assert (flags == 3'b101) else valueError("move changed the flags"); // N and C
				end
			end
		end
	endtask

	task automatic otherGroupsTest();
		logic [31:0] rnd;
		for (int g = 0; g < 3; g++) begin
			for (int t = 0; t < 2; t++) begin
				rnd = nextRand();
				issuePlain({2'(g), rnd[13:0]}); // no reads, writes or flags
			end
		end
		for (int i = 0; i < 4; i++) begin
			issuePlain(aluWord(OP_MOV, MODE_REG_REG, 4'(i), 4'(i))); // contents unchanged
		end
	endtask

	task automatic ignoredStrobeTest();
		issueInstr(aluWord(OP_ADD, MODE_REG_U4, 4'd2, 4'd1), 1'b1,
			aluWord(OP_MOV, MODE_RB_U8, 4'hF, 4'hF));
		assert (lastAddr == 4'd2) else valueError("second strobe replaced the held word");
		issuePlain(aluWord(OP_MOV, MODE_REG_REG, REG_RB, REG_RB)); // RB untouched
	endtask

	task automatic randomStreamTest();
		logic [31:0] rnd;
		for (int n = 0; n < 200; n++) begin
			rnd = nextRand();
			issuePlain({2'b11, rnd[13:0]});
		end
	endtask

	initial begin
		rstN        = 1'b0;
		instrStrobe = 1'b0;
		instr       = 16'h0000;
		errCount    = 0;
		rngState    = 32'd2115;
		mdlFlags    = 3'b000;
		lastAddr    = 4'h0;
		lastData    = 16'h0000;
		for (int i = 0; i < 16; i++) begin
			mdlRegs[i] = 16'h0000;
		end
		repeat (4) @(negedge CLK); // four rising edges in reset
		rstN = 1'b1;
		@(negedge CLK);
		resetStateTest();
		immediateModesTest();
		operationsTest();
		otherGroupsTest();
		ignoredStrobeTest();
		randomStreamTest();
		if (errCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: tb/cpuAluCore_assert.sv
// bound checks: one-hot phase while busy, write-back only in commit, held word under ignored strobe
`timescale 1ns/1ps

module cpuAluCore_assert (
	input logic        CLK,
	input logic        rstN,
	input logic        instrStrobe,
	input logic        busy,
	input logic        fetch,
	input logic        decode,
	input logic        execute,
	input logic        commit,
	input logic        resultValid,
	input logic [15:0] instrReg
);

	// one phase bit per busy cycle
	phaseOneHot: assert property (@(posedge CLK) disable iff (!rstN)
		busy |-> $onehot({fetch, decode, execute, commit}))
		else $error("phase bits not one-hot while busy");

	writeInCommit: assert property (@(posedge CLK) disable iff (!rstN)
		resultValid |-> commit) // trace only in the last phase
		else $error("write-back outside the commit phase");

	// strobe during busy must not reload the word
	heldWordStable: assert property (@(posedge CLK) disable iff (!rstN)
		(instrStrobe && busy) |=> $stable(instrReg))
		else $error("held instruction changed by a strobe while busy");

endmodule

bind cpuAluCore cpuAluCore_assert u_assert (
	.CLK(CLK), .rstN(rstN), .instrStrobe(instrStrobe), .busy(busy),
	.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
	.resultValid(resultValid), .instrReg(instrReg)
);
